// ==== dma_pkg.sv ====
// Shared widths, register map, FIFO depths and packed types for the ADC DMA endpoint
package dma_pkg;

    // --------------------------------------------------
    // Widths and depths
    // --------------------------------------------------
    localparam int DATA_W            = 32;
    localparam int ADC_W             = 12;
    localparam int ADC_MODE_W        = 2;
    localparam int REG_ADDR_W        = 2;
    localparam int ADDR_FIFO_DEPTH   = 16;
    localparam int SAMPLE_FIFO_DEPTH = 64;
    localparam int SAMPLE_CNT_W      = $clog2(SAMPLE_FIFO_DEPTH + 1);
    localparam int PKT_LEN_W         = 6;      // Packet length is field + 1

    typedef logic [DATA_W-1:0]     data_word_t;
    typedef logic [DATA_W-1:0]     buf_addr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // --------------------------------------------------
    // Register map and bit positions
    // --------------------------------------------------
    localparam reg_addr_t REG_CTRL     = 2'd0;
    localparam reg_addr_t REG_BUF_POST = 2'd1;
    localparam reg_addr_t REG_BUF_RET  = 2'd2;
    localparam reg_addr_t REG_STATUS   = 2'd3;

    localparam int CTRL_ENABLE_BIT   = 0;
    localparam int CTRL_PKT_LEN_LSB  = 8;
    localparam int CTRL_ADC_MODE_LSB = 28;
    localparam int CTRL_FLUSH_BIT    = 31;     // Self-clearing, never stored

    localparam int STAT_FREE_EMPTY = 0;
    localparam int STAT_FREE_FULL  = 1;
    localparam int STAT_RET_EMPTY  = 2;
    localparam int STAT_RET_FULL   = 3;
    localparam int STAT_OVERFLOW   = 4;

    // --------------------------------------------------
    // Packed bundles
    // --------------------------------------------------
    typedef struct packed {
        logic       wr;                        // Write strobe
        logic       rd;                        // Read strobe
        reg_addr_t  addr;
        data_word_t wdata;
    } reg_req_t;

    typedef struct packed {
        logic                 enable;
        logic [PKT_LEN_W-1:0] pkt_len;
    } ctrl_cfg_t;

    typedef struct packed {
        logic       sof;                       // Header beat
        logic       eof;                       // Last data beat
        data_word_t data;
    } tx_beat_t;

endpackage

// ==== sync_fifo.sv ====
// First-word-fall-through synchronous FIFO with flush and fill count
`timescale 1ns/1ns

module sync_fifo #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = dma_pkg::data_word_t
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush_i,
    input  logic                         push_i,
    input  payload_t                     wdata_i,
    input  logic                         pop_i,
    output payload_t                     rdata_o,
    output logic                         empty_o,
    output logic                         full_o,
    output logic [$clog2(DEPTH+1)-1:0]   count_o
);

    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic                       do_push;
    logic                       do_pop;

    assign do_push = push_i && !full_o;        // Full FIFO drops the word
    assign do_pop  = pop_i && !empty_o;

    assign empty_o = (count_o == '0);
    assign full_o  = (count_o == DEPTH);
    assign rdata_o = mem[rd_ptr];              // Head word visible at once

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;       // Wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_o <= count_o + 1'b1;
                2'b01:   count_o <= count_o - 1'b1;
                default: count_o <= count_o;
            endcase
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

endmodule

// ==== ctrl_regs.sv ====
// Host register block with control, buffer post, buffer return and status registers
`timescale 1ns/1ns

module ctrl_regs (
    input  logic                              clk,
    input  logic                              rst_n,
    input  dma_pkg::reg_req_t                 req_i,
    output dma_pkg::data_word_t               rdata_o,
    output dma_pkg::ctrl_cfg_t                cfg_o,
    output logic [dma_pkg::ADC_MODE_W-1:0]    adc_mode_o,
    output logic                              flush_o,
    output logic                              post_push_o,
    output dma_pkg::buf_addr_t                post_addr_o,
    output logic                              ret_pop_o,
    input  dma_pkg::buf_addr_t                ret_addr_i,
    input  logic                              free_empty_i,
    input  logic                              free_full_i,
    input  logic                              ret_empty_i,
    input  logic                              ret_full_i,
    input  logic                              overflow_i
);

    dma_pkg::data_word_t ctrl_q;
    dma_pkg::data_word_t status_w;
    logic                ctrl_wr;

    // --------------------------------------------------
    // Write decode
    // --------------------------------------------------
    assign ctrl_wr     = req_i.wr && (req_i.addr == dma_pkg::REG_CTRL);
    assign post_push_o = req_i.wr && (req_i.addr == dma_pkg::REG_BUF_POST) && !free_full_i;
    assign post_addr_o = req_i.wdata;
    assign ret_pop_o   = req_i.rd && (req_i.addr == dma_pkg::REG_BUF_RET) && !ret_empty_i;

    assign cfg_o.enable  = ctrl_q[dma_pkg::CTRL_ENABLE_BIT];
    assign cfg_o.pkt_len = ctrl_q[dma_pkg::CTRL_PKT_LEN_LSB +: dma_pkg::PKT_LEN_W];
    assign adc_mode_o    = ctrl_q[dma_pkg::CTRL_ADC_MODE_LSB +: dma_pkg::ADC_MODE_W];

    always_comb begin
        status_w = '0;
        status_w[dma_pkg::STAT_FREE_EMPTY] = free_empty_i;
        status_w[dma_pkg::STAT_FREE_FULL]  = free_full_i;
        status_w[dma_pkg::STAT_RET_EMPTY]  = ret_empty_i;
        status_w[dma_pkg::STAT_RET_FULL]   = ret_full_i;
        status_w[dma_pkg::STAT_OVERFLOW]   = overflow_i;
    end

    // --------------------------------------------------
    // Registers and read path
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q  <= '0;
            flush_o <= 1'b0;
            rdata_o <= '0;
        end else begin
            flush_o <= 1'b0;                                 // One-cycle pulse
            if (ctrl_wr) begin
                ctrl_q <= req_i.wdata;
                ctrl_q[dma_pkg::CTRL_FLUSH_BIT] <= 1'b0;
                flush_o <= req_i.wdata[dma_pkg::CTRL_FLUSH_BIT];
            end
            if (req_i.rd) begin
                case (req_i.addr)
                    dma_pkg::REG_CTRL:    rdata_o <= ctrl_q;
                    dma_pkg::REG_BUF_RET: rdata_o <= ret_empty_i ? '0 : ret_addr_i;
                    dma_pkg::REG_STATUS:  rdata_o <= status_w;
                    default:              rdata_o <= '0;     // Post register is write-only
                endcase
            end
        end
    end

endmodule

// ==== adc_packer.sv ====
// ADC sample capture and packing into 32-bit sample words
`timescale 1ns/1ns

module adc_packer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          enable_i,
    input  logic                          adc_strobe_i,
    input  logic [dma_pkg::ADC_W-1:0]     adc1_i,
    input  logic [dma_pkg::ADC_W-1:0]     adc2_i,
    input  logic                          fifo_full_i,
    input  logic                          flush_i,
    output logic                          push_o,
    output dma_pkg::data_word_t           word_o,
    output logic                          overflow_o
);

    dma_pkg::data_word_t packed_w;
    logic                pend_q;

    always_comb begin
        packed_w = '0;
        packed_w[dma_pkg::ADC_W-1:0] = adc1_i;                   // Channel 1 low half
        packed_w[dma_pkg::DATA_W/2 +: dma_pkg::ADC_W] = adc2_i;  // Channel 2 high half
    end

    assign push_o = pend_q && !fifo_full_i;

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            pend_q     <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            pend_q <= adc_strobe_i && enable_i;
            if (pend_q && fifo_full_i) begin
                overflow_o <= 1'b1;                          // Sticky until flush
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adc_strobe_i) begin
            word_o <= packed_w;
        end
    end

endmodule

// ==== tx_engine.sv ====
// Transmit FSM sending header and data beats and retiring used buffer addresses
`timescale 1ns/1ns

module tx_engine (
    input  logic                               clk,
    input  logic                               rst_n,
    input  dma_pkg::ctrl_cfg_t                 cfg_i,
    input  logic                               free_empty_i,
    input  dma_pkg::buf_addr_t                 free_addr_i,
    output logic                               free_pop_o,
    input  logic [dma_pkg::SAMPLE_CNT_W-1:0]   sample_count_i,
    input  dma_pkg::data_word_t                sample_word_i,
    output logic                               sample_pop_o,
    input  logic                               ret_full_i,
    output logic                               ret_push_o,
    output dma_pkg::buf_addr_t                 ret_addr_o,
    output dma_pkg::tx_beat_t                  tx_beat_o,
    output logic                               tx_valid_o,
    input  logic                               tx_ready_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_DATA,
        ST_RETIRE
    } state_t;

    state_t                          state_q;
    logic [dma_pkg::PKT_LEN_W-1:0]   beats_left_q;
    dma_pkg::buf_addr_t              addr_q;
    logic                            start;

    // Whole packet of samples must be queued, return FIFO needs a free slot
    assign start = (state_q == ST_IDLE) && cfg_i.enable && !free_empty_i && !ret_full_i
                   && (sample_count_i > dma_pkg::SAMPLE_CNT_W'(cfg_i.pkt_len));

    assign free_pop_o = start;
    assign ret_push_o = (state_q == ST_RETIRE);
    assign ret_addr_o = addr_q;

    // --------------------------------------------------
    // Beat generation
    // --------------------------------------------------
    always_comb begin
        tx_beat_o    = '0;
        tx_valid_o   = 1'b0;
        sample_pop_o = 1'b0;
        case (state_q)
            ST_HEADER: begin
                tx_valid_o     = 1'b1;
                tx_beat_o.sof  = 1'b1;
                tx_beat_o.data = addr_q;                     // Header carries buffer address
            end
            ST_DATA: begin
                tx_valid_o     = 1'b1;
                tx_beat_o.eof  = (beats_left_q == '0);
                tx_beat_o.data = sample_word_i;              // FIFO head, stable until popped
                sample_pop_o   = tx_ready_i;
            end
            default: begin
                tx_valid_o = 1'b0;
            end
        endcase
    end

    // --------------------------------------------------
    // State and beat counter
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= ST_IDLE;
            beats_left_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q      <= ST_HEADER;
                        beats_left_q <= cfg_i.pkt_len;       // Length frozen for the packet
                    end
                end
                ST_HEADER: begin
                    if (tx_ready_i) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (tx_ready_i) begin
                        if (beats_left_q == '0) begin
                            state_q <= ST_RETIRE;
                        end else begin
                            beats_left_q <= beats_left_q - 1'b1;
                        end
                    end
                end
                default: state_q <= ST_IDLE;                 // Retire lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= free_addr_i;                           // Held until retire
        end
    end

endmodule

// ==== dma_ep_top.sv ====
// Top level of the ADC DMA endpoint with register block, packer, engine and FIFOs
`timescale 1ns/1ns

module dma_ep_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  dma_pkg::reg_req_t                 reg_req_i,
    output dma_pkg::data_word_t               reg_rdata_o,
    input  logic                              adc_strobe_i,
    input  logic [dma_pkg::ADC_W-1:0]         adc1_i,
    input  logic [dma_pkg::ADC_W-1:0]         adc2_i,
    output logic [dma_pkg::ADC_MODE_W-1:0]    adc_mode_o,
    output dma_pkg::tx_beat_t                 tx_beat_o,
    output logic                              tx_valid_o,
    input  logic                              tx_ready_i
);

    dma_pkg::ctrl_cfg_t                cfg;
    logic                              flush;
    logic                              overflow;
    // Free address FIFO
    logic                              post_push;
    dma_pkg::buf_addr_t                post_addr;
    logic                              free_pop;
    dma_pkg::buf_addr_t                free_addr;
    logic                              free_empty;
    logic                              free_full;
    // Return address FIFO
    logic                              ret_push;
    dma_pkg::buf_addr_t                ret_push_addr;
    logic                              ret_pop;
    dma_pkg::buf_addr_t                ret_addr;
    logic                              ret_empty;
    logic                              ret_full;
    // Sample FIFO
    logic                              sample_push;
    dma_pkg::data_word_t               sample_wdata;
    logic                              sample_pop;
    dma_pkg::data_word_t               sample_word;
    logic                              sample_full;
    logic [dma_pkg::SAMPLE_CNT_W-1:0]  sample_count;

    ctrl_regs regs_i (
        .clk, .rst_n, .req_i(reg_req_i), .rdata_o(reg_rdata_o), .cfg_o(cfg),
        .adc_mode_o, .flush_o(flush), .post_push_o(post_push), .post_addr_o(post_addr),
        .ret_pop_o(ret_pop), .ret_addr_i(ret_addr), .free_empty_i(free_empty),
        .free_full_i(free_full), .ret_empty_i(ret_empty), .ret_full_i(ret_full),
        .overflow_i(overflow)
    );

    adc_packer packer_i (
        .clk, .rst_n, .enable_i(cfg.enable), .adc_strobe_i, .adc1_i, .adc2_i,
        .fifo_full_i(sample_full), .flush_i(flush), .push_o(sample_push),
        .word_o(sample_wdata), .overflow_o(overflow)
    );

    sync_fifo #(.DEPTH(dma_pkg::ADDR_FIFO_DEPTH), .payload_t(dma_pkg::buf_addr_t)) free_fifo_i (
        .clk, .rst_n, .flush_i(flush), .push_i(post_push), .wdata_i(post_addr),
        .pop_i(free_pop), .rdata_o(free_addr), .empty_o(free_empty), .full_o(free_full),
        .count_o()
    );

    sync_fifo #(.DEPTH(dma_pkg::ADDR_FIFO_DEPTH), .payload_t(dma_pkg::buf_addr_t)) ret_fifo_i (
        .clk, .rst_n, .flush_i(flush), .push_i(ret_push), .wdata_i(ret_push_addr),
        .pop_i(ret_pop), .rdata_o(ret_addr), .empty_o(ret_empty), .full_o(ret_full),
        .count_o()
    );

    sync_fifo #(.DEPTH(dma_pkg::SAMPLE_FIFO_DEPTH), .payload_t(dma_pkg::data_word_t)) smp_fifo_i (
        .clk, .rst_n, .flush_i(flush), .push_i(sample_push), .wdata_i(sample_wdata),
        .pop_i(sample_pop), .rdata_o(sample_word), .empty_o(), .full_o(sample_full),
        .count_o(sample_count)
    );

    tx_engine engine_i (
        .clk, .rst_n, .cfg_i(cfg), .free_empty_i(free_empty), .free_addr_i(free_addr),
        .free_pop_o(free_pop), .sample_count_i(sample_count), .sample_word_i(sample_word),
        .sample_pop_o(sample_pop), .ret_full_i(ret_full), .ret_push_o(ret_push),
        .ret_addr_o(ret_push_addr), .tx_beat_o, .tx_valid_o, .tx_ready_i
    );

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and synchronous reset generator
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;                          // Released away from the active edge
    end

endmodule

// ==== dma_ep_assertions.sv ====
// Concurrent assertions on the transmit stream and FIFO pops bound to tx_engine
`timescale 1ns/1ns

module dma_ep_assertions (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              tx_valid_o,
    input  logic                              tx_ready_i,
    input  dma_pkg::tx_beat_t                 tx_beat_o,
    input  logic                              sample_pop_o,
    input  logic [dma_pkg::SAMPLE_CNT_W-1:0]  sample_count_i,
    input  logic                              free_pop_o,
    input  logic                              free_empty_i,
    input  dma_pkg::buf_addr_t                free_addr_i
);

    int unsigned fail_count = 0;               // Failed assertion count

    beat_held: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_beat_o))
        else begin
            fail_count++;
            $error("Beat changed or dropped while the consumer stalled");
        end

    sof_then_data: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid_o && tx_ready_i && tx_beat_o.sof |=> tx_valid_o && !tx_beat_o.sof)
        else begin
            fail_count++;
            $error("Accepted header was not followed by a data beat");
        end

    sample_pop_safe: assert property (@(posedge clk) disable iff (!rst_n)
        sample_pop_o |-> sample_count_i != '0)
        else begin
            fail_count++;
            $error("Sample FIFO popped while empty");
        end

    free_pop_safe: assert property (@(posedge clk) disable iff (!rst_n)
        free_pop_o |=> !$past(free_empty_i) && tx_valid_o && tx_beat_o.sof
                       && (tx_beat_o.data == $past(free_addr_i)))
        else begin
            fail_count++;
            $error("Free address popped while empty or not sent as the next header");
        end

endmodule

bind tx_engine dma_ep_assertions asrt_i (
    .clk(clk), .rst_n(rst_n), .tx_valid_o(tx_valid_o), .tx_ready_i(tx_ready_i),
    .tx_beat_o(tx_beat_o), .sample_pop_o(sample_pop_o), .sample_count_i(sample_count_i),
    .free_pop_o(free_pop_o), .free_empty_i(free_empty_i), .free_addr_i(free_addr_i)
);

// ==== dma_ep_tb.sv ====
// Testbench for the ADC DMA endpoint with LFSR stimulus, queue model, compare tasks, watchdog
`timescale 1ns/1ns

module dma_ep_tb;

    localparam int          CLK_PERIOD      = 4;
    localparam logic [31:0] SEED            = 32'h06490050;
    localparam int          ADDRS_PER_ROUND = 4;
    localparam int          N_ROUNDS        = 3;          // Third round runs after the flush
    localparam int          MAX_PKT_WORDS   = 16;         // Rounds use a 4-bit length field
    localparam int          OVF_STROBES     = dma_pkg::SAMPLE_FIFO_DEPTH + 6;
    // Strobes and ready both run near half rate so each word gets four cycles
    localparam int ROUND_CYCLES = 4 * ADDRS_PER_ROUND * (MAX_PKT_WORDS + 1) + 40;
    localparam int TEST_CYCLES  = 60 + N_ROUNDS * ROUND_CYCLES + OVF_STROBES + 40;
    localparam int WATCHDOG_NS  = TEST_CYCLES * CLK_PERIOD + 2000;

    logic                             clk;
    logic                             rst_n;
    dma_pkg::reg_req_t                reg_req;
    dma_pkg::data_word_t              reg_rdata;
    logic                             adc_strobe;
    logic [dma_pkg::ADC_W-1:0]        adc1;
    logic [dma_pkg::ADC_W-1:0]        adc2;
    logic [dma_pkg::ADC_MODE_W-1:0]   adc_mode;
    dma_pkg::tx_beat_t                tx_beat;
    logic                             tx_valid;
    logic                             tx_ready;

    // Reference model state
    logic [31:0]                      lfsr;
    dma_pkg::data_word_t              sample_q[$];
    dma_pkg::buf_addr_t               free_q[$];
    dma_pkg::buf_addr_t               ret_q[$];
    logic                             en_model;
    logic                             ovf_model;
    logic [dma_pkg::PKT_LEN_W-1:0]    len_model;
    logic                             in_pkt;
    int                               beats_left;
    dma_pkg::buf_addr_t               cur_addr;
    int                               pkt_done;
    int                               word_errs;
    int                               beat_errs;
    int                               addr_errs;
    int                               other_errs;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(5)) clk_gen_i (.clk, .rst_n);

    dma_ep_top dut_i (
        .clk, .rst_n, .reg_req_i(reg_req), .reg_rdata_o(reg_rdata), .adc_strobe_i(adc_strobe),
        .adc1_i(adc1), .adc2_i(adc2), .adc_mode_o(adc_mode), .tx_beat_o(tx_beat),
        .tx_valid_o(tx_valid), .tx_ready_i(tx_ready)
    );

    // --------------------------------------------------
    // Random bits and compare tasks
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_word(input string name, input dma_pkg::data_word_t exp,
                              input dma_pkg::data_word_t act);
        if (act !== exp) begin
            word_errs++;
            $display("ERROR %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input dma_pkg::buf_addr_t exp,
                              input dma_pkg::buf_addr_t act);
        if (act !== exp) begin
            addr_errs++;
            $display("ERROR %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_beat(input dma_pkg::tx_beat_t exp, input dma_pkg::tx_beat_t act);
        if (act !== exp) begin
            beat_errs++;
            $display("ERROR %0t ns tx_beat_o expected sof=%b eof=%b %h actual sof=%b eof=%b %h",
                     $time, exp.sof, exp.eof, exp.data, act.sof, act.eof, act.data);
        end
    endtask

    function automatic dma_pkg::data_word_t expected_status();
        dma_pkg::data_word_t s;
        s = '0;
        s[dma_pkg::STAT_FREE_EMPTY] = (free_q.size() == 0);
        s[dma_pkg::STAT_FREE_FULL]  = (free_q.size() == dma_pkg::ADDR_FIFO_DEPTH);
        s[dma_pkg::STAT_RET_EMPTY]  = (ret_q.size() == 0);
        s[dma_pkg::STAT_RET_FULL]   = (ret_q.size() == dma_pkg::ADDR_FIFO_DEPTH);
        s[dma_pkg::STAT_OVERFLOW]   = ovf_model;
        return s;
    endfunction

    // --------------------------------------------------
    // Stream monitor and cycle step
    // --------------------------------------------------
    task automatic capture_beat(input dma_pkg::tx_beat_t beat);
        dma_pkg::tx_beat_t exp;
        exp = '0;
        if (!in_pkt) begin
            if (free_q.size() == 0) begin
                other_errs++;
                $display("At %0t ns a packet started with no posted address left", $time);
            end else begin
                cur_addr   = free_q.pop_front();
                exp.sof    = 1'b1;
                exp.data   = cur_addr;
                check_beat(exp, beat);
                in_pkt     = 1'b1;
                beats_left = int'(len_model) + 1;
            end
        end else if (sample_q.size() == 0) begin
            other_errs++;
            $display("At %0t ns a data beat was sent with no sample queued", $time);
        end else begin
            exp.eof  = (beats_left == 1);
            exp.data = sample_q.pop_front();
            check_beat(exp, beat);
            beats_left--;
            if (beats_left == 0) begin
                in_pkt = 1'b0;
                ret_q.push_back(cur_addr);
                pkt_done++;
            end
        end
    endtask

    // One clock cycle with a new ready level and the beat taken when valid meets it
    task automatic tick();
        logic [31:0] r;
        @(negedge clk);
        rand_bits(1, r);
        tx_ready = r[0];
        if (tx_valid && tx_ready) begin
            capture_beat(tx_beat);
        end
    endtask

    task automatic reg_write(input dma_pkg::reg_addr_t addr, input dma_pkg::data_word_t data);
        reg_req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        if (addr == dma_pkg::REG_CTRL) begin
            en_model  = data[dma_pkg::CTRL_ENABLE_BIT];
            len_model = data[dma_pkg::CTRL_PKT_LEN_LSB +: dma_pkg::PKT_LEN_W];
            if (data[dma_pkg::CTRL_FLUSH_BIT]) begin
                sample_q.delete();
                free_q.delete();
                ret_q.delete();
                ovf_model = 1'b0;
            end
        end else if (addr == dma_pkg::REG_BUF_POST && free_q.size() < dma_pkg::ADDR_FIFO_DEPTH) begin
            free_q.push_back(data);
        end
        tick();
        reg_req.wr = 1'b0;
    endtask

    task automatic reg_read(input dma_pkg::reg_addr_t addr, output dma_pkg::data_word_t data);
        reg_req = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
        tick();
        reg_req.rd = 1'b0;
        data = reg_rdata;                      // Registered one cycle after the strobe
    endtask

    task automatic strobe_sample();
        logic [31:0]         r;
        dma_pkg::data_word_t w;
        rand_bits(24, r);
        adc1       = r[11:0];
        adc2       = r[23:12];
        adc_strobe = 1'b1;
        w          = '0;
        w[0 +: dma_pkg::ADC_W]  = r[11:0];
        w[16 +: dma_pkg::ADC_W] = r[23:12];
        if (en_model) begin
            if (sample_q.size() < dma_pkg::SAMPLE_FIFO_DEPTH) begin
                sample_q.push_back(w);
            end else begin
                ovf_model = 1'b1;
            end
        end
    endtask

    // --------------------------------------------------
    // Test sequences
    // --------------------------------------------------
    task automatic ctrl_readback();
        logic [31:0]         w;
        dma_pkg::data_word_t exp;
        dma_pkg::data_word_t got;
        for (int i = 0; i < 4; i++) begin
            rand_bits(32, w);
            reg_write(dma_pkg::REG_CTRL, w);
            check_word("adc_mode_o", dma_pkg::data_word_t'(w[dma_pkg::CTRL_ADC_MODE_LSB +: 2]),
                       dma_pkg::data_word_t'(adc_mode));
            reg_read(dma_pkg::REG_CTRL, got);
            exp = w;
            exp[dma_pkg::CTRL_FLUSH_BIT] = 1'b0;
            check_word("reg_rdata_o(ctrl)", exp, got);
        end
    endtask

    task automatic run_round(input int n_addr);
        logic [31:0]         r;
        dma_pkg::data_word_t ctrl;
        dma_pkg::data_word_t got;
        int                  target;
        int                  sent;
        int                  total;
        rand_bits(4, r);
        ctrl = '0;
        ctrl[dma_pkg::CTRL_ENABLE_BIT] = 1'b1;
        ctrl[dma_pkg::CTRL_PKT_LEN_LSB +: dma_pkg::PKT_LEN_W] = dma_pkg::PKT_LEN_W'(r[3:0]);
        reg_write(dma_pkg::REG_CTRL, ctrl);
        target = pkt_done + n_addr;
        for (int i = 0; i < n_addr; i++) begin
            rand_bits(32, r);
            reg_write(dma_pkg::REG_BUF_POST, r);
        end
        total = n_addr * (int'(len_model) + 1);
        sent  = 0;
        while (sent < total) begin
            rand_bits(1, r);
            if (r[0]) begin
                strobe_sample();
                sent++;
            end else begin
                adc_strobe = 1'b0;
            end
            tick();
        end
        adc_strobe = 1'b0;
        while (pkt_done < target) begin
            tick();                            // Remaining packets drain
        end
        repeat (3) tick();                     // Last retire reaches the return FIFO
        reg_read(dma_pkg::REG_STATUS, got);
        check_word("reg_rdata_o(status)", expected_status(), got);
        while (ret_q.size() > 0) begin
            reg_read(dma_pkg::REG_BUF_RET, got);
            check_addr("reg_rdata_o(buf_ret)", ret_q.pop_front(), got);
        end
        reg_read(dma_pkg::REG_BUF_RET, got);
        check_addr("reg_rdata_o(buf_ret empty)", '0, got);
        reg_read(dma_pkg::REG_STATUS, got);
        check_word("reg_rdata_o(status)", expected_status(), got);
    endtask

    task automatic overflow_and_flush();
        logic [31:0]         r;
        dma_pkg::data_word_t got;
        reg_write(dma_pkg::REG_CTRL, 32'h1);   // Enabled with no address so the engine idles
        for (int i = 0; i < OVF_STROBES; i++) begin
            strobe_sample();
            tick();
        end
        adc_strobe = 1'b0;
        repeat (3) tick();
        reg_read(dma_pkg::REG_STATUS, got);
        check_word("reg_rdata_o(status overflow)", expected_status(), got);
        reg_write(dma_pkg::REG_CTRL, 32'h0);
        for (int i = 0; i < 3; i++) begin
            rand_bits(32, r);
            reg_write(dma_pkg::REG_BUF_POST, r);
        end
        reg_read(dma_pkg::REG_STATUS, got);
        check_word("reg_rdata_o(status posted)", expected_status(), got);
        reg_write(dma_pkg::REG_CTRL, 32'h8000_0000);
        tick();                                // Flush pulse lands one cycle after the write
        reg_read(dma_pkg::REG_STATUS, got);
        check_word("reg_rdata_o(status flushed)", expected_status(), got);
        run_round(2);                          // Stale samples would show up here
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        dma_pkg::data_word_t got;
        int                  total_errs;
        reg_req    = '0;
        adc_strobe = 1'b0;
        adc1       = '0;
        adc2       = '0;
        tx_ready   = 1'b0;
        lfsr       = SEED;
        en_model   = 1'b0;
        ovf_model  = 1'b0;
        len_model  = '0;
        in_pkt     = 1'b0;
        beats_left = 0;
        cur_addr   = '0;
        pkt_done   = 0;
        word_errs  = 0;
        beat_errs  = 0;
        addr_errs  = 0;
        other_errs = 0;
        wait (rst_n === 1'b1);
        tick();
        check_word("reg_rdata_o(reset)", '0, reg_rdata);
        if (tx_valid !== 1'b0) begin
            other_errs++;
            $display("At %0t ns tx_valid_o was not low after reset", $time);
        end
        reg_read(dma_pkg::REG_STATUS, got);
        check_word("reg_rdata_o(status reset)", expected_status(), got);
        ctrl_readback();
        run_round(ADDRS_PER_ROUND);
        run_round(ADDRS_PER_ROUND);
        overflow_and_flush();
        repeat (4) tick();
        total_errs = word_errs + beat_errs + addr_errs + other_errs
                     + int'(dut_i.engine_i.asrt_i.fail_count);
        $display("Errors: word=%0d beat=%0d addr=%0d other=%0d assertion=%0d",
                 word_errs, beat_errs, addr_errs, other_errs,
                 dut_i.engine_i.asrt_i.fail_count);
        if (total_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== project.f ====
dma_pkg.sv
sync_fifo.sv
ctrl_regs.sv
adc_packer.sv
tx_engine.sv
dma_ep_top.sv
tb_clock_gen.sv
dma_ep_assertions.sv
dma_ep_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dma_ep_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0
PASS_MSG  ?= Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
